/* common/host_pkg.sv */
package host_pkg;

   // ########################################
   // Host bus widths
   // ########################################

   localparam int WADDR_W = 20;          // Word address width.
   localparam int DATA_W  = 32;          // Read data width.

   // ########################################
   // Host operations
   // ########################################

   typedef enum logic [1:0] {
      OP_READ_WORD   = 2'd0,             // Flash array word.
      OP_READ_STATUS = 2'd1,             // Status register byte.
      OP_READ_ID     = 2'd2              // JEDEC ID, 3 bytes.
   } host_op_e;

   // ########################################
   // Request and response
   // ########################################

   // Taken on a ren strobe while busy is low.
   typedef struct packed {
      host_op_e             op;
      logic [WADDR_W-1:0]   waddr;
   } host_req_t;

   typedef struct packed {
      logic [DATA_W-1:0]    rdata;       // First flash byte in bits 7:0.
   } host_rsp_t;

endpackage

/* common/flash_pkg.sv */
package flash_pkg;

   // ########################################
   // Flash commands
   // ########################################

   typedef enum logic [7:0] {
      CMD_READ        = 8'h03,           // Slow read, 24-bit address.
      CMD_READ_STATUS = 8'h05,
      CMD_READ_ID     = 8'h9F
   } flash_cmd_e;

   // ########################################
   // Address map and bit counts
   // ########################################

   localparam int CMD_BITS    = 8;
   localparam int ADDR_BITS   = 24;
   localparam int STATUS_BITS = 8;
   localparam int ID_BITS     = 24;
   localparam int MAX_BITS    = 32;      // Longest TX or RX phase.
   localparam int CNT_W       = $clog2(MAX_BITS + 1);

   // Byte address of host word 0.
   localparam logic [ADDR_BITS-1:0] FLASH_BASE = 24'h10_0000;

   // ########################################
   // Transfer descriptor
   // ########################################

   // Command and address are left-aligned in tx_word.
   typedef struct packed {
      logic [MAX_BITS-1:0]  tx_word;
      logic [CNT_W-1:0]     tx_bits;
      logic [CNT_W-1:0]     rx_bits;
      host_pkg::host_op_e   op;          // Carried through to result.
   } xfer_desc_t;

endpackage

/* spi_flash/spi_cmd_decode.sv */
module spi_cmd_decode (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  ren,
   input  host_pkg::host_req_t   req,
   input  logic                  busy_eng,
   output logic                  busy,
   output logic                  start,
   output flash_pkg::xfer_desc_t desc
);

   import host_pkg::*;
   import flash_pkg::*;

   logic                  accept;
   logic                  pending;
   logic [ADDR_BITS-1:0]  byte_addr;
   xfer_desc_t            desc_d;

   // Strobes seen while busy are dropped.
   assign accept = ren && !busy;
   assign busy   = pending || busy_eng;

   assign byte_addr = FLASH_BASE + ADDR_BITS'({req.waddr, 2'b00});

   // ########################################
   // Descriptor selection
   // ########################################

   always_comb begin
      desc_d.op = req.op;
      case (req.op)
         OP_READ_WORD: begin
            desc_d.tx_word = {CMD_READ, byte_addr};
            desc_d.tx_bits = CNT_W'(CMD_BITS + ADDR_BITS);
            desc_d.rx_bits = CNT_W'(MAX_BITS);
         end
         OP_READ_STATUS: begin
            desc_d.tx_word = {CMD_READ_STATUS, {ADDR_BITS{1'b0}}};
            desc_d.tx_bits = CNT_W'(CMD_BITS);
            desc_d.rx_bits = CNT_W'(STATUS_BITS);
         end
         OP_READ_ID: begin
            desc_d.tx_word = {CMD_READ_ID, {ADDR_BITS{1'b0}}};
            desc_d.tx_bits = CNT_W'(CMD_BITS);
            desc_d.rx_bits = CNT_W'(ID_BITS);
         end
         default: begin
            desc_d.tx_word = '0;         // Unused op code.
            desc_d.tx_bits = CNT_W'(CMD_BITS);
            desc_d.rx_bits = CNT_W'(STATUS_BITS);
         end
      endcase
   end

   // ########################################
   // Start pulse and pending flag
   // ########################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         start   <= 1'b0;
         pending <= 1'b0;
      end else begin
         start <= accept;
         if (accept) begin
            pending <= 1'b1;           // Covers the gap until the engine runs.
         end else if (busy_eng) begin
            pending <= 1'b0;
         end
      end
   end

   // Stays stable for the whole transfer.
   always_ff @(posedge clk) begin
      if (accept) begin
         desc <= desc_d;
      end
   end

endmodule

/* spi_flash/spi_shift_engine.sv */
module spi_shift_engine (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  flash_pkg::xfer_desc_t desc,
   output logic                  busy_eng,
   output logic [31:0]           rx_data,
   output logic                  rx_done,
   output logic                  ss,
   output logic                  sck,
   output logic                  mosi,
   input  logic                  miso
);

   import flash_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      START,
      TX,
      RX,
      DONE
   } state_e;

   state_e                state;
   logic [CNT_W-1:0]      bit_cnt;
   logic [MAX_BITS-1:0]   tx_sr;
   logic [MAX_BITS-1:0]   rx_sr;

   logic                  load;
   logic                  tx_shift;
   logic                  rx_sample;

   // ########################################
   // Shift strobes
   // ########################################

   assign load      = (state == IDLE) && start;
   assign tx_shift  = (state == START) || ((state == TX) && sck && (bit_cnt != '0));
   assign rx_sample = (state == RX) && !sck;  // SCK about to rise.

   assign busy_eng = (state != IDLE);
   assign rx_done  = (state == DONE);
   assign rx_data  = rx_sr;

   // ########################################
   // Control FSM
   // ########################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= IDLE;
         bit_cnt <= '0;
         ss      <= 1'b1;
         sck     <= 1'b1;
         mosi    <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  state <= START;
                  ss    <= 1'b0;
               end
            end
            START: begin
               state   <= TX;
               sck     <= 1'b0;        // First falling edge.
               mosi    <= tx_sr[MAX_BITS-1];
               bit_cnt <= desc.tx_bits;
            end
            TX: begin
               if (!sck) begin
                  sck     <= 1'b1;     // Flash samples MOSI here.
                  bit_cnt <= bit_cnt - 1'b1;
               end else if (bit_cnt == '0) begin
                  state   <= RX;
                  sck     <= 1'b0;
                  mosi    <= 1'b0;
                  bit_cnt <= desc.rx_bits;
               end else begin
                  sck  <= 1'b0;
                  mosi <= tx_sr[MAX_BITS-1];
               end
            end
            RX: begin
               if (!sck) begin
                  sck     <= 1'b1;
                  bit_cnt <= bit_cnt - 1'b1;
               end else if (bit_cnt == '0) begin
                  state <= DONE;
                  ss    <= 1'b1;       // SCK already high.
               end else begin
                  sck <= 1'b0;
               end
            end
            DONE: begin
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // ########################################
   // Shift registers
   // ########################################

   always_ff @(posedge clk) begin
      if (load) begin
         tx_sr <= desc.tx_word;
      end else if (tx_shift) begin
         tx_sr <= {tx_sr[MAX_BITS-2:0], 1'b0};
      end

      // MSB first, result ends up right-aligned.
      if (load) begin
         rx_sr <= '0;
      end else if (rx_sample) begin
         rx_sr <= {rx_sr[MAX_BITS-2:0], miso};
      end
   end

endmodule

/* spi_flash/spi_read_result.sv */
module spi_read_result (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  flash_pkg::xfer_desc_t desc,
   input  logic [31:0]           rx_data,
   input  logic                  rx_done,
   output host_pkg::host_rsp_t   rsp,
   output logic                  rd_valid
);

   import host_pkg::*;
   import flash_pkg::*;

   host_op_e           op_q;
   logic [DATA_W-1:0]  rdata_d;

   // Op of the transfer in flight.
   always_ff @(posedge clk) begin
      if (start) begin
         op_q <= desc.op;
      end
   end

   // ########################################
   // Formatting
   // ########################################

   always_comb begin
      case (op_q)
         OP_READ_WORD: begin
            // First byte on the wire goes to the low byte.
            rdata_d = {rx_data[7:0], rx_data[15:8], rx_data[23:16], rx_data[31:24]};
         end
         OP_READ_STATUS: begin
            rdata_d = {{(DATA_W - STATUS_BITS){1'b0}}, rx_data[STATUS_BITS-1:0]};
         end
         OP_READ_ID: begin
            rdata_d = {{(DATA_W - ID_BITS){1'b0}}, rx_data[ID_BITS-1:0]};
         end
         default: begin
            rdata_d = '0;
         end
      endcase
   end

   // ########################################
   // Response register
   // ########################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rx_done;          // One cycle after DONE.
      end
   end

   // Held until the next response.
   always_ff @(posedge clk) begin
      if (rx_done) begin
         rsp.rdata <= rdata_d;
      end
   end

endmodule

/* source/spi_flash_reader.sv */
module spi_flash_reader (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  ren,
   input  host_pkg::host_req_t   req,
   output logic                  busy,
   output host_pkg::host_rsp_t   rsp,
   output logic                  rd_valid,
   output logic                  ss,
   output logic                  sck,
   output logic                  mosi,
   input  logic                  miso
);

   import flash_pkg::*;

   logic          start;
   logic          busy_eng;
   xfer_desc_t    desc;
   logic [31:0]   rx_data;
   logic          rx_done;

   // ########################################
   // Request decode
   // ########################################

   spi_cmd_decode u_decode (
      .clk      (clk),
      .rst_n    (rst_n),
      .ren      (ren),
      .req      (req),
      .busy_eng (busy_eng),
      .busy     (busy),
      .start    (start),
      .desc     (desc)
   );

   // ########################################
   // SPI engine
   // ########################################

   spi_shift_engine u_engine (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start),
      .desc     (desc),
      .busy_eng (busy_eng),
      .rx_data  (rx_data),
      .rx_done  (rx_done),
      .ss       (ss),
      .sck      (sck),
      .mosi     (mosi),
      .miso     (miso)
   );

   // Response formatting.
   spi_read_result u_result (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start),
      .desc     (desc),
      .rx_data  (rx_data),
      .rx_done  (rx_done),
      .rsp      (rsp),
      .rd_valid (rd_valid)
   );

endmodule

/* tb/flash_model.sv */
module flash_model (
   input  logic ss,
   input  logic sck,
   input  logic mosi,
   output logic miso
);

   import flash_pkg::*;

   localparam logic [31:0] SEED = 32'h7463_a693;

   logic [7:0]   mem [logic [23:0]];   // Filled on first read.
   logic [31:0]  shift_in;
   logic [31:0]  fill;
   logic [23:0]  addr;
   logic [23:0]  baddr;
   logic [7:0]   out_byte;
   flash_cmd_e   cmd;
   int           in_cnt;
   int           hdr_bits;
   int           out_cnt;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   initial miso = 1'b0;

   always @(negedge ss) begin
      in_cnt   = 0;
      out_cnt  = 0;
      hdr_bits = CMD_BITS;
   end

   // Command and address come in on rising SCK.
   always @(posedge sck) begin
      if (!ss && in_cnt < hdr_bits) begin
         shift_in = {shift_in[30:0], mosi};
         in_cnt++;
         if (in_cnt == CMD_BITS) begin
            cmd = flash_cmd_e'(shift_in[7:0]);
            if (cmd == CMD_READ) begin
               hdr_bits = CMD_BITS + ADDR_BITS;
            end
         end
         if (in_cnt == CMD_BITS + ADDR_BITS) begin
            addr = shift_in[23:0];
         end
      end
   end

   // Data goes out on falling SCK, MSB first.
   always @(negedge sck) begin
      if (!ss && in_cnt >= hdr_bits) begin
         case (cmd)
            CMD_READ: begin
               baddr = addr + 24'(out_cnt / 8);
               if (!mem.exists(baddr)) begin
                  fill       = xorshift32(xorshift32(SEED ^ {8'h00, baddr}));
                  mem[baddr] = fill[7:0];
               end
               out_byte = mem[baddr];
            end
            CMD_READ_STATUS: out_byte = 8'h5A;
            CMD_READ_ID:     out_byte = 8'(24'hEF4016 >> (8 * (2 - (out_cnt / 8) % 3)));
            default:         out_byte = 8'hFF;
         endcase
         miso = out_byte[7 - out_cnt % 8];
         out_cnt++;
      end
   end

endmodule

/* tb/spi_flash_checker.sv */
module spi_flash_checker (
   input logic clk,
   input logic rst_n,
   input logic ss,
   input logic sck,
   input logic mosi,
   input logic busy,
   input logic rd_valid
);

   sck_idle_high: assert property (@(posedge clk) disable iff (!rst_n) ss |-> sck)
      else $error("SCK low while SS is high");

   // MOSI only moves with a falling SCK in mode 3.
   mosi_stable: assert property (@(posedge clk) disable iff (!rst_n) sck |-> $stable(mosi))
      else $error("MOSI changed while SCK was high");

   idle_deselect: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> ss)
      else $error("SS low while the controller is idle");

   valid_pulse: assert property (@(posedge clk) disable iff (!rst_n) rd_valid |=> !rd_valid)
      else $error("rd_valid held longer than one cycle");

endmodule

bind spi_flash_reader spi_flash_checker checker0 (
   .clk      (clk),
   .rst_n    (rst_n),
   .ss       (ss),
   .sck      (sck),
   .mosi     (mosi),
   .busy     (busy),
   .rd_valid (rd_valid)
);

/* tb/tb_spi_flash.sv */
module tb_spi_flash;

   import host_pkg::*;
   import flash_pkg::*;

   localparam int          PERIOD    = 100;
   localparam int          N_ENTRIES = 12;
   localparam logic [31:0] SEED      = 32'h7463_a693;

   typedef struct packed {
      host_op_e         op;
      logic [19:0]      waddr;
      logic             poke;          // Extra strobes while busy.
      host_rsp_t        exp;
   } entry_t;

   logic        clk;
   logic        rst_n;
   logic        ren;
   host_req_t   req;
   logic        busy;
   host_rsp_t   rsp;
   logic        rd_valid;
   logic        ss;
   logic        sck;
   logic        mosi;
   logic        miso;
   entry_t      stim [N_ENTRIES];
   int          rsp_count;

   spi_flash_reader dut0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .ren      (ren),
      .req      (req),
      .busy     (busy),
      .rsp      (rsp),
      .rd_valid (rd_valid),
      .ss       (ss),
      .sck      (sck),
      .mosi     (mosi),
      .miso     (miso)
   );

   flash_model flash0 (.ss(ss), .sck(sck), .mosi(mosi), .miso(miso));

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [7:0] flash_byte(input logic [23:0] a);
      logic [31:0] v;
      v = xorshift32(xorshift32(SEED ^ {8'h00, a}));
      return v[7:0];
   endfunction

   function automatic host_rsp_t expected_rsp(input host_op_e op, input logic [19:0] waddr);
      logic [23:0] a;
      host_rsp_t   r;
      a = FLASH_BASE + 24'({waddr, 2'b00});
      case (op)
         OP_READ_WORD:   r.rdata = {flash_byte(a + 24'd3), flash_byte(a + 24'd2),
                                    flash_byte(a + 24'd1), flash_byte(a)};
         OP_READ_STATUS: r.rdata = 32'h0000_005A;
         OP_READ_ID:     r.rdata = 32'h00EF_4016;
         default:        r.rdata = '0;
      endcase
      return r;
   endfunction

   // Cycles from driving ren to seeing rd_valid.
   function automatic int expected_latency(input host_op_e op);
      case (op)
         OP_READ_WORD:   return 2 * (CMD_BITS + ADDR_BITS + 32) + 4;
         OP_READ_STATUS: return 2 * (CMD_BITS + STATUS_BITS) + 4;
         default:        return 2 * (CMD_BITS + ID_BITS) + 4;
      endcase
   endfunction

   task automatic set_entry(input int idx, input host_op_e op, input logic [19:0] waddr,
                            input logic poke);
      stim[idx].op    = op;
      stim[idx].waddr = waddr;
      stim[idx].poke  = poke;
      stim[idx].exp   = expected_rsp(op, waddr);
   endtask

   task automatic build_table();
      logic [31:0] rng;
      set_entry(0, OP_READ_WORD,   20'h00000, 1'b0);
      set_entry(1, OP_READ_WORD,   20'hFFFFF, 1'b0);  // Top word.
      set_entry(2, OP_READ_STATUS, 20'h00000, 1'b0);
      set_entry(3, OP_READ_ID,     20'h00000, 1'b0);
      set_entry(4, OP_READ_WORD,   20'h12345, 1'b1);
      set_entry(5, OP_READ_STATUS, 20'h00000, 1'b1);
      rng = SEED;
      for (int i = 6; i < N_ENTRIES; i++) begin
         rng = xorshift32(rng);
         set_entry(i, host_op_e'(2'(rng[31:16] % 3)), rng[19:0], 1'b0);
      end
   endtask

   task automatic abort_run();
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation stopped.");
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR: %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_rsp(input int idx, input host_rsp_t got, input host_rsp_t exp);
      if (got !== exp) begin
         $display("ERROR: rsp.rdata got %h expected %h (entry %0d)", got.rdata, exp.rdata, idx);
         abort_run();
      end
   endtask

   task automatic check_latency(input int idx, input int got, input int exp);
      if (got != exp) begin
         $display("ERROR: rd_valid latency got %h expected %h (entry %0d)", got, exp, idx);
         abort_run();
      end
   endtask

   task automatic wait_idle();
      while (busy) begin
         @(posedge clk);
         #10;
      end
   endtask

   task automatic run_request(input int idx);
      entry_t e;
      int     cycles;
      e         = stim[idx];
      ren       = 1'b1;
      req.op    = e.op;
      req.waddr = e.waddr;
      cycles    = 0;
      do begin
         @(posedge clk);
         #10;
         cycles++;
         ren = e.poke && (cycles == 1 || cycles == 20);
         if (ren) begin
            req.op    = (e.op == OP_READ_ID) ? OP_READ_WORD : OP_READ_ID;
            req.waddr = ~e.waddr;        // Must be dropped.
         end
      end while (!rd_valid);
      check_latency(idx, cycles, expected_latency(e.op));
      check_rsp(idx, rsp, e.exp);
   endtask

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   always @(negedge clk) begin
      if (rst_n && rd_valid) begin
         rsp_count++;
      end
   end

   initial begin
      #((N_ENTRIES * 140 + 60) * PERIOD);
      $display("Watchdog expired before all requests completed.");
      abort_run();
   end

   initial begin
      rst_n     = 1'b0;
      ren       = 1'b0;
      req       = '0;
      rsp_count = 0;
      build_table();
      repeat (2) @(posedge clk);
      #10;
      rst_n = 1'b1;
      @(posedge clk);
      #10;
      check_level("ss", ss, 1'b1);
      check_level("sck", sck, 1'b1);
      check_level("mosi", mosi, 1'b0);
      check_level("busy", busy, 1'b0);
      check_level("rd_valid", rd_valid, 1'b0);
      for (int i = 0; i < N_ENTRIES; i++) begin
         wait_idle();
         run_request(i);
      end
      wait_idle();
      repeat (4) @(posedge clk);
      #10;
      if (rsp_count == N_ENTRIES) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         $display("Got %0d responses for %0d accepted requests.", rsp_count, N_ENTRIES);
         abort_run();
      end
   end

endmodule

/* project.f */
common/host_pkg.sv
common/flash_pkg.sv
spi_flash/spi_cmd_decode.sv
spi_flash/spi_shift_engine.sv
spi_flash/spi_read_result.sv
source/spi_flash_reader.sv
tb/flash_model.sv
tb/spi_flash_checker.sv
tb/tb_spi_flash.sv
